// ==== source/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	// ----------------------------------------
	// melody ids
	// ----------------------------------------
	localparam int MELODY_W = 4;

	localparam logic [MELODY_W-1:0] MEL_HIT       = 4'd11;
	localparam logic [MELODY_W-1:0] MEL_LOST      = 4'd12;
	localparam logic [MELODY_W-1:0] MEL_POWER     = 4'd13;
	localparam logic [MELODY_W-1:0] MEL_JEWEL     = 4'd14;
	localparam logic [MELODY_W-1:0] MEL_OBJECTIVE = 4'd15;

	// ----------------------------------------
	// note table widths and timing
	// ----------------------------------------
	localparam int NOTE_W        = 4;  // code 0 = rest
	localparam int DUR_W         = 3;  // dur 0 = end of melody
	localparam int STEP_W        = 2;  // max four notes
	localparam int TICK_CYCLES   = 16; // cycles per duration unit, short for sim
	localparam int TICK_W        = $clog2(TICK_CYCLES);
	localparam int HALF_PERIOD_W = 8;

	// note code to half period in clock cycles, 0 means silence
	function automatic logic [HALF_PERIOD_W-1:0] note_half_period(
		input logic [NOTE_W-1:0] code
	);
		logic [HALF_PERIOD_W-1:0] hp;
		if (code == '0)
			hp = '0;
		else
			hp = HALF_PERIOD_W'(4) + (HALF_PERIOD_W'(code) << 1); // 4 + 2*code
		return hp;
	endfunction

endpackage

`default_nettype wire

// ==== source/audio_mux.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_mux (
	input  logic                          clk,
	input  logic                          resetN,
	input  logic                          speed_power_up,
	input  logic                          live_power_up,
	input  logic                          bomb_power_up,
	input  logic                          clock_power_up,
	input  logic                          jewel_power_up,
	input  logic                          player_objective,
	input  logic                          player_hit,
	input  logic                          game_lost,      // level, edge counts
	input  logic                          melody_ended,
	output logic                          start_melody,   // one cycle pulse
	output logic [audio_pkg::MELODY_W-1:0] melody_select, // held until next start
	output logic                          sound_busy
);

	import audio_pkg::*;

	typedef enum logic {
		S_IDLE,
		S_PLAY
	} mux_state_t;

	mux_state_t state;

	logic game_lost_d;    // last sampled level
	logic game_lost_rise; // high one cycle on 0->1
	logic any_power;      // non-jewel power-ups
	logic any_event;

	// ----------------------------------------
	// game_lost edge detect
	// ----------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			game_lost_d <= 1'b0;
		end else begin
			game_lost_d <= game_lost; // tracks even while busy, so edges get lost
		end
	end

	assign game_lost_rise = game_lost & ~game_lost_d;

	assign any_power = speed_power_up | live_power_up | bomb_power_up | clock_power_up;
	assign any_event = jewel_power_up | any_power | player_objective | player_hit
		| game_lost_rise;

	// ----------------------------------------
	// idle / play FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state         <= S_IDLE;
			melody_select <= '0;
			start_melody  <= 1'b0;
		end else begin
			start_melody <= 1'b0; // default, pulse only
			case (state)
				S_IDLE: begin
					if (any_event) begin
						state        <= S_PLAY;
						start_melody <= 1'b1;
					end
					// fixed priority, jewel first
					if (jewel_power_up)
						melody_select <= MEL_JEWEL;
					else if (any_power)
						melody_select <= MEL_POWER;
					else if (player_objective)
						melody_select <= MEL_OBJECTIVE;
					else if (player_hit)
						melody_select <= MEL_HIT;
					else if (game_lost_rise)
						melody_select <= MEL_LOST;
				end
				S_PLAY: begin
					// events dropped here
					if (melody_ended)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign sound_busy = (state == S_PLAY);

endmodule

`default_nettype wire

// ==== source/melody_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module melody_rom (
	input  logic [audio_pkg::MELODY_W-1:0] melody_select,
	input  logic [audio_pkg::STEP_W-1:0]   step_index,
	output logic [audio_pkg::NOTE_W-1:0]   note_code,
	output logic [audio_pkg::DUR_W-1:0]    note_dur
);

	import audio_pkg::*;

	logic [NOTE_W+DUR_W-1:0] entry; // {code, dur}

	// ----------------------------------------
	// note table, {code, units}
	// ----------------------------------------
	always_comb begin
		entry = '0; // unknown id -> empty melody
		case (melody_select)
			MEL_HIT: begin // short low drop
				case (step_index)
					2'd0:    entry = {4'd3, 3'd1};
					2'd1:    entry = {4'd1, 3'd2};
					default: entry = {4'd0, 3'd0}; // end
				endcase
			end
			MEL_LOST: begin // slow fall, rest in the middle
				case (step_index)
					2'd0:    entry = {4'd8, 3'd2};
					2'd1:    entry = {4'd0, 3'd1}; // rest
					2'd2:    entry = {4'd4, 3'd2};
					default: entry = {4'd1, 3'd3};
				endcase
			end
			MEL_POWER: begin
				case (step_index)
					2'd0:    entry = {4'd5, 3'd1};
					2'd1:    entry = {4'd9, 3'd1};
					2'd2:    entry = {4'd12, 3'd2};
					default: entry = {4'd0, 3'd0};
				endcase
			end
			MEL_JEWEL: begin // two high blips
				case (step_index)
					2'd0:    entry = {4'd12, 3'd1};
					2'd1:    entry = {4'd15, 3'd1};
					default: entry = {4'd0, 3'd0};
				endcase
			end
			MEL_OBJECTIVE: begin // rising arpeggio
				case (step_index)
					2'd0:    entry = {4'd6, 3'd1};
					2'd1:    entry = {4'd8, 3'd1};
					2'd2:    entry = {4'd10, 3'd1};
					default: entry = {4'd13, 3'd3};
				endcase
			end
			default: entry = '0;
		endcase
	end

	assign {note_code, note_dur} = entry;

endmodule

`default_nettype wire

// ==== source/note_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module note_sequencer (
	input  logic                        clk,
	input  logic                        resetN,
	input  logic                        start_melody,
	input  logic [audio_pkg::NOTE_W-1:0] note_code,     // from rom
	input  logic [audio_pkg::DUR_W-1:0]  note_dur,      // from rom
	output logic [audio_pkg::STEP_W-1:0] step_index,    // next note to fetch
	output logic [audio_pkg::NOTE_W-1:0] note_code_out,
	output logic                        note_valid,    // high while playing
	output logic                        melody_ended   // one cycle pulse
);

	import audio_pkg::*;

	logic [DUR_W-1:0]  unit_cnt;  // units left in current note
	logic [TICK_W-1:0] tick_cnt;  // cycles inside one unit
	logic              last_note; // current note came from step 3
	logic              tick_wrap;
	logic              note_done;
	logic              load;

	assign tick_wrap = (tick_cnt == TICK_W'(TICK_CYCLES - 1));
	assign note_done = note_valid && tick_wrap && (unit_cnt == DUR_W'(1));
	assign load      = start_melody || note_done; // fetch from rom this edge

	// ----------------------------------------
	// step / unit / tick counters
	// ----------------------------------------
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			step_index    <= '0;
			unit_cnt      <= '0;
			tick_cnt      <= '0;
			last_note     <= 1'b0;
			note_code_out <= '0;
			note_valid    <= 1'b0;
			melody_ended  <= 1'b0;
		end else begin
			melody_ended <= 1'b0;
			if (load) begin
				if (note_dur == '0 || (note_done && last_note)) begin
					// zero duration or past step 3
					note_valid   <= 1'b0;
					melody_ended <= 1'b1;
					step_index   <= '0; // ready for next start
					last_note    <= 1'b0;
				end else begin
					note_code_out <= note_code;
					unit_cnt      <= note_dur;
					tick_cnt      <= '0;
					note_valid    <= 1'b1;
					last_note     <= (step_index == '1);
					step_index    <= step_index + 1'b1; // prefetch next
				end
			end else if (note_valid) begin
				tick_cnt <= tick_cnt + 1'b1; // wraps at TICK_CYCLES
				if (tick_wrap)
					unit_cnt <= unit_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/tone_generator.sv ====
`timescale 1ns/1ns
`default_nettype none

module tone_generator (
	input  logic                        clk,
	input  logic                        resetN,
	input  logic [audio_pkg::NOTE_W-1:0] note_code,
	input  logic                        note_valid,
	output logic                        audio_out  // square wave
);

	import audio_pkg::*;

	logic [HALF_PERIOD_W-1:0] half_period;
	logic [HALF_PERIOD_W-1:0] half_cnt;   // cycles until next toggle
	logic [NOTE_W:0]          tone_prev;  // {valid, code} last cycle
	logic                     silent;
	logic                     note_change;

	assign half_period = note_half_period(note_code);
	assign silent      = !note_valid || (note_code == '0); // rest or idle
	assign note_change = ({note_valid, note_code} != tone_prev);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			audio_out <= 1'b0;
			half_cnt  <= '0;
			tone_prev <= '0;
		end else begin
			tone_prev <= {note_valid, note_code};
			if (silent) begin
				audio_out <= 1'b0;
				half_cnt  <= '0;
			end else if (note_change) begin
				// change seen one edge late, hence -2
				audio_out <= 1'b0;
				half_cnt  <= half_period - HALF_PERIOD_W'(2);
			end else if (half_cnt == '0) begin
				audio_out <= ~audio_out;
				half_cnt  <= half_period - HALF_PERIOD_W'(1);
			end else begin
				half_cnt <= half_cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/game_sound_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_sound_top (
	input  logic                          clk,
	input  logic                          resetN,
	input  logic                          speed_power_up,
	input  logic                          live_power_up,
	input  logic                          bomb_power_up,
	input  logic                          clock_power_up,
	input  logic                          jewel_power_up,
	input  logic                          player_objective,
	input  logic                          player_hit,
	input  logic                          game_lost,
	output logic                          audio_out,
	output logic [audio_pkg::MELODY_W-1:0] melody_select,
	output logic                          sound_busy
);

	import audio_pkg::*;

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic              start_melody;
	logic              melody_ended;
	logic [STEP_W-1:0] step_index;
	logic [NOTE_W-1:0] rom_code;   // rom -> sequencer
	logic [DUR_W-1:0]  rom_dur;
	logic [NOTE_W-1:0] play_code;  // sequencer -> tone
	logic              note_valid;

	audio_mux u_audio_mux (
		.clk              (clk),
		.resetN           (resetN),
		.speed_power_up   (speed_power_up),
		.live_power_up    (live_power_up),
		.bomb_power_up    (bomb_power_up),
		.clock_power_up   (clock_power_up),
		.jewel_power_up   (jewel_power_up),
		.player_objective (player_objective),
		.player_hit       (player_hit),
		.game_lost        (game_lost),
		.melody_ended     (melody_ended),
		.start_melody     (start_melody),
		.melody_select    (melody_select),
		.sound_busy       (sound_busy)
	);

	melody_rom u_melody_rom (
		.melody_select (melody_select),
		.step_index    (step_index),
		.note_code     (rom_code),
		.note_dur      (rom_dur)
	);

	note_sequencer u_note_sequencer (
		.clk           (clk),
		.resetN        (resetN),
		.start_melody  (start_melody),
		.note_code     (rom_code),
		.note_dur      (rom_dur),
		.step_index    (step_index),
		.note_code_out (play_code),
		.note_valid    (note_valid),
		.melody_ended  (melody_ended)
	);

	tone_generator u_tone_generator (
		.clk        (clk),
		.resetN     (resetN),
		.note_code  (play_code),
		.note_valid (note_valid),
		.audio_out  (audio_out)
	);

endmodule

`default_nettype wire

// ==== verif/game_sound_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_sound_assert (
	input logic                           clk,
	input logic                           resetN,
	input logic                           start_melody,
	input logic                           sound_busy,
	input logic [audio_pkg::MELODY_W-1:0] melody_select
);

	// ----------------------------------------
	// audio_mux start and hold rules
	// ----------------------------------------
	start_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
		start_melody |=> !start_melody)
		else $error("start_melody held longer than one cycle");

	// busy already high, no fresh start
	no_start_busy: assert property (@(posedge clk) disable iff (!resetN)
		sound_busy |=> !start_melody)
		else $error("start_melody while sound_busy was high");

	select_stable: assert property (@(posedge clk) disable iff (!resetN)
		sound_busy |=> $stable(melody_select))
		else $error("melody_select changed while busy");

endmodule

bind audio_mux game_sound_assert u_game_sound_assert (
	.clk           (clk),
	.resetN        (resetN),
	.start_melody  (start_melody),
	.sound_busy    (sound_busy),
	.melody_select (melody_select)
);

`default_nettype wire

// ==== verif/game_sound_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module game_sound_tb;

	import audio_pkg::*;

	localparam int IDLE_GAP = 40; // quiet cycles watched after each melody

	logic                clk;
	logic                resetN;
	logic                speed_power_up;
	logic                live_power_up;
	logic                bomb_power_up;
	logic                clock_power_up;
	logic                jewel_power_up;
	logic                player_objective;
	logic                player_hit;
	logic                game_lost;
	logic                audio_out;
	logic [MELODY_W-1:0] melody_select;
	logic                sound_busy;

	// pattern table, one entry per test
	string               t_name[$];
	logic [7:0]          t_events[$];
	logic [MELODY_W-1:0] t_melody[$];
	int                  t_half[$];
	int                  t_units[$];

	integer seed;
	int     cycle_cnt = 0;
	int     cycle_limit = 0; // set once the patterns are read

	game_sound_top u_game_sound_top (
		.clk              (clk),
		.resetN           (resetN),
		.speed_power_up   (speed_power_up),
		.live_power_up    (live_power_up),
		.bomb_power_up    (bomb_power_up),
		.clock_power_up   (clock_power_up),
		.jewel_power_up   (jewel_power_up),
		.player_objective (player_objective),
		.player_hit       (player_hit),
		.game_lost        (game_lost),
		.audio_out        (audio_out),
		.melody_select    (melody_select),
		.sound_busy       (sound_busy)
	);

	always #50 clk = ~clk; // 100 ns period

	// ----------------------------------------
	// error exit and compare tasks
	// ----------------------------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_melody(input string test, input logic [MELODY_W-1:0] exp_id,
		input logic [MELODY_W-1:0] act_id);
		if (act_id !== exp_id)
			stop_with_error($sformatf("FAILED %s: melody_select expected %0d actual %0d",
				test, exp_id, act_id));
	endtask

	// exact when slack is 0, else act may run up to slack over
	task automatic check_count(input string test, input string what, input int exp_val,
		input int act_val, input int slack);
		if (act_val < exp_val || act_val > exp_val + slack)
			stop_with_error($sformatf("FAILED %s: %s expected %0d (+%0d) actual %0d",
				test, what, exp_val, slack, act_val));
	endtask

	function automatic bit known_melody(input logic [MELODY_W-1:0] id);
		return id == MEL_HIT || id == MEL_LOST || id == MEL_POWER
			|| id == MEL_JEWEL || id == MEL_OBJECTIVE;
	endfunction

	// ----------------------------------------
	// pattern file
	// ----------------------------------------
	task automatic load_patterns();
		int         fd;
		int         n;
		string      line;
		string      name;
		logic [7:0] ev;
		int         mel;
		int         hp;
		int         units;
		fd = $fopen("verif/game_sound_patterns.txt", "r");
		if (fd == 0)
			stop_with_error("cannot open verif/game_sound_patterns.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#")
				continue; // blank or column notes
			n = $sscanf(line, "%s %h %d %d %d", name, ev, mel, hp, units);
			if (n != 5)
				stop_with_error({"malformed pattern line: ", line});
			if (!known_melody(MELODY_W'(mel)))
				stop_with_error({"pattern names an unknown melody: ", line});
			t_name.push_back(name);
			t_events.push_back(ev);
			t_melody.push_back(MELODY_W'(mel));
			t_half.push_back(hp);
			t_units.push_back(units);
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic drive_strobes(input logic [6:0] s);
		speed_power_up   <= s[0];
		live_power_up    <= s[1];
		bomb_power_up    <= s[2];
		clock_power_up   <= s[3];
		jewel_power_up   <= s[4];
		player_objective <= s[5];
		player_hit       <= s[6];
	endtask

	task automatic run_test(input int idx);
		string               name;
		logic [7:0]          ev;
		logic [MELODY_W-1:0] exp_id;
		int                  busy_len;
		int                  elapsed;   // cycles since sound_busy rose
		int                  rise_at;   // first audio_out high, -1 if none
		int                  burst_end;
		int                  late_busy;
		integer              rnd;
		name      = t_name[idx];
		ev        = t_events[idx];
		exp_id    = t_melody[idx];
		burst_end = t_units[idx] * TICK_CYCLES - 8; // bursts stop well before the end
		if (sound_busy)
			stop_with_error({name, ": sound_busy already high before the events"});
		@(posedge clk);
		drive_strobes(ev[6:0]);
		if (ev[7])
			game_lost <= 1'b1; // level, held through the melody
		@(posedge clk);
		drive_strobes('0);
		@(negedge clk);
		while (!sound_busy)
			@(negedge clk); // cycle counter guards this
		check_melody(name, exp_id, melody_select);
		busy_len = 1;
		elapsed  = 0;
		rise_at  = -1;
		while (sound_busy) begin
			@(posedge clk);
			if (elapsed < burst_end && (elapsed % TICK_CYCLES) < 4) begin
				rnd = $random(seed);
				drive_strobes(rnd[6:0]); // must be ignored while busy
			end else begin
				drive_strobes('0);
			end
			@(negedge clk);
			if (sound_busy) begin
				busy_len++;
				elapsed++;
				check_melody(name, exp_id, melody_select);
				if (audio_out && rise_at < 0)
					rise_at = elapsed;
			end
		end
		drive_strobes('0);
		check_count(name, "busy cycles", t_units[idx] * TICK_CYCLES, busy_len, 3);
		// note 0 starts one cycle after sound_busy rises
		check_count(name, "first half period", t_half[idx],
			(rise_at < 0) ? 0 : rise_at - 1, 0);
		late_busy = 0;
		repeat (IDLE_GAP) begin
			@(negedge clk);
			if (sound_busy)
				late_busy++; // held game_lost must not restart
		end
		check_count(name, "busy cycles after melody end", 0, late_busy, 0);
		if (ev[7]) begin
			@(posedge clk);
			game_lost <= 1'b0;
			repeat (2) @(posedge clk);
		end
	endtask

	// ----------------------------------------
	// timeout
	// ----------------------------------------
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
			stop_with_error("timeout: melody never ended");
	end

	initial begin
		int total_units;
		clk              = 1'b0;
		resetN           <= 1'b0;
		speed_power_up   <= 1'b0;
		live_power_up    <= 1'b0;
		bomb_power_up    <= 1'b0;
		clock_power_up   <= 1'b0;
		jewel_power_up   <= 1'b0;
		player_objective <= 1'b0;
		player_hit       <= 1'b0;
		game_lost        <= 1'b0;
		seed             = 10;
		load_patterns();
		total_units = 0;
		foreach (t_units[i])
			total_units += t_units[i];
		cycle_limit = 2 * total_units * TICK_CYCLES + 200 * t_name.size();
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_melody("reset", MELODY_W'(0), melody_select); // reset values
		check_count("reset", "sound_busy", 0, int'(sound_busy), 0);
		check_count("reset", "audio_out", 0, int'(audio_out), 0);
		@(posedge clk);
		resetN <= 1'b1; // after 8 cycles
		repeat (2) @(posedge clk);
		foreach (t_name[i])
			run_test(i);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/game_sound_patterns.txt ====
# name  events(hex b7 lost b6 hit b5 objective b4 jewel b3 clock b2 bomb b1 live b0 speed)
#       melody_id  first_half_period(0 = no toggle in first note)  total_units
hit_only          40  11  10  3
lost_edge         80  12  20  8
speed_power       01  13  14  4
live_power        02  13  14  4
bomb_power        04  13  14  4
clock_power       08  13  14  4
jewel_only        10  14   0  2
objective_only    20  15  16  6
prio_jewel_all    ff  14   0  2
prio_power_obj    21  13  14  4
prio_obj_hit      60  15  16  6
prio_hit_lost     c0  11  10  3
prio_clock_hit    48  13  14  4
prio_obj_lost     a0  15  16  6
lost_again        80  12  20  8
jewel_bomb        14  14   0  2

// ==== vlog.f ====
source/audio_pkg.sv
source/audio_mux.sv
source/melody_rom.sv
source/note_sequencer.sv
source/tone_generator.sv
source/game_sound_top.sv
verif/game_sound_assert.sv
verif/game_sound_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the game sound testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ns --top-module game_sound_tb \
	-f vlog.f -o game_sound_sim > build.log 2>&1 || { echo "BUILD ERROR, see build.log"; exit 1; }
./obj_dir/game_sound_sim > sim.log 2>&1
grep -q "Test failed" sim.log && { echo "SIM FAIL, see sim.log"; exit 1; }
grep -q "Test completed successfully" sim.log && echo "SIM PASS" || { echo "SIM FAIL, see sim.log"; exit 1; }
